// File: design/rd_atop_pkg.sv
// AXI read to PCIe read request mapper, shared definitions
// Field widths and types of the AR FIFO word, request kinds,
// TLP header constants and the read tag construction pattern
package rd_atop_pkg;

   // AXI AR field widths
   localparam int USER_W = 3;
   localparam int SIZE_W = 3;
   localparam int LEN_W = 8;
   localparam int ADDR_W = 64;
   localparam int ID_W = 4;

   // AR FIFO word layout, user at bit 0 and ID on top
   localparam int USER_LSB = 0;
   localparam int SIZE_LSB = USER_LSB + USER_W;
   localparam int LEN_LSB = SIZE_LSB + SIZE_W;
   localparam int ADDR_LSB = LEN_LSB + LEN_W;
   localparam int ID_LSB = ADDR_LSB + ADDR_W;
   localparam int AR_WORD_W = ID_LSB + ID_W;

   // TLP side widths
   localparam int KIND_W = 2;
   localparam int TLP_LEN_W = 10;
   localparam int BE_W = 4;
   localparam int TAG_W = 8;
   localparam int REQ_ID_W = 16;
   localparam int DW_W = 32;
   localparam int HDR_W = 4 * DW_W;
   localparam int REC_DATA_W = ID_W + 1;

   // Beat count plus the largest size shift (128-byte beats are 32 DW)
   localparam int LEN_CALC_W = LEN_W + 1 + 5;

   typedef logic [USER_W-1:0]     ar_user_t;
   typedef logic [SIZE_W-1:0]     ax_size_t;
   typedef logic [LEN_W-1:0]      ax_len_t;
   typedef logic [ADDR_W-1:0]     axi_addr_t;
   typedef logic [ID_W-1:0]       ar_id_t;
   typedef logic [AR_WORD_W-1:0]  ar_word_t;
   typedef logic [KIND_W-1:0]     req_kind_t;
   typedef logic [TLP_LEN_W-1:0]  tlp_len_t;
   typedef logic [BE_W-1:0]       dw_be_t;
   typedef logic [TAG_W-1:0]      tlp_tag_t;
   typedef logic [REQ_ID_W-1:0]   requester_id_t;
   typedef logic [HDR_W-1:0]      tlp_hdr_t;
   typedef logic [REC_DATA_W-1:0] rec_data_t;

   // Decoded request kinds
   localparam req_kind_t KIND_NONE = 2'd0;
   localparam req_kind_t KIND_MEM32 = 2'd1;
   localparam req_kind_t KIND_IO32 = 2'd2;
   localparam req_kind_t KIND_MEM64 = 2'd3;

   // Format and type codes for non-posted reads without data
   localparam logic [2:0] FMT_3DW_NO_DATA = 3'b000;
   localparam logic [2:0] FMT_4DW_NO_DATA = 3'b001;
   localparam logic [4:0] TYPE_MEM_RD = 5'b00000;
   localparam logic [4:0] TYPE_IO_RD = 5'b00010;

   // Fixed header attribute fields
   localparam logic [2:0] HDR_TC = 3'b000;
   localparam logic       HDR_ATTR2 = 1'b1;
   localparam logic       HDR_TH = 1'b1;
   localparam logic [1:0] HDR_ATTR = 2'b10;

   // Read tag construction
   localparam logic       TAG_READ_MARK = 1'b1;
   localparam logic [2:0] TAG_SCRAMBLE = 3'b010;

endpackage

// File: design/ar_req_if.sv
// AR request bundle
// Carries the unpacked AR fields and the decoded request kind
// from the decoder to the length, tag and header blocks
interface ar_req_if;
   import rd_atop_pkg::*;

   ar_user_t  user;
   ax_size_t  size;
   ax_len_t   len;
   axi_addr_t addr;
   ar_id_t    id;
   req_kind_t kind;

   // Unpacks and decodes, drives everything
   modport decoder (output user, size, len, addr, id, kind);

   // Length and byte enable calculation
   modport length (input kind, size, len, addr);

   // Read tag derivation
   modport tag (input id);

   // Header assembly
   modport header (input kind, addr);

endinterface

// File: design/rd_req_decode.sv
// AR request decoder
// Slices the AR FIFO word into its fields and decodes the user
// bits into a read request kind, none when the block is disabled
module rd_req_decode (
   input  rd_atop_pkg::ar_word_t ar_fifo_data,
   input  logic                  rd_atop_en,
   ar_req_if.decoder             req
);
   import rd_atop_pkg::*;

   // Field slicing, user in the low bits and ID on top
   assign req.user = ar_fifo_data[USER_LSB +: USER_W];
   assign req.size = ar_fifo_data[SIZE_LSB +: SIZE_W];
   assign req.len  = ar_fifo_data[LEN_LSB +: LEN_W];
   assign req.addr = ar_fifo_data[ADDR_LSB +: ADDR_W];
   assign req.id   = ar_fifo_data[ID_LSB +: ID_W];

   // Kind decode
   // user[2] picks 64-bit addressing, user[1:0] picks the space
   always_comb begin
      req.kind = KIND_NONE;
      if (rd_atop_en) begin
         case (req.user[1:0])
            2'b01: begin
               // Memory read, either address width
               if (req.user[2]) begin
                  req.kind = KIND_MEM64;
               end else begin
                  req.kind = KIND_MEM32;
               end
            end
            2'b10: begin
               // I/O space only has 32-bit addresses
               if (req.user[2]) begin
                  req.kind = KIND_NONE;
               end else begin
                  req.kind = KIND_IO32;
               end
            end
            default: begin
               // 00 idle, 11 messages not handled
               req.kind = KIND_NONE;
            end
         endcase
      end
   end

endmodule

// File: design/rd_len_be_calc.sv
// TLP length and byte enable calculation
// Converts AXI beat size and count into a doubleword length and
// picks first and last DW byte enables for the request kind
module rd_len_be_calc (
   ar_req_if.length             req,
   output rd_atop_pkg::tlp_len_t length,
   output rd_atop_pkg::dw_be_t   first_be,
   output rd_atop_pkg::dw_be_t   last_be
);
   import rd_atop_pkg::*;

   logic [LEN_CALC_W-1:0] beats;
   logic [LEN_CALC_W-1:0] dw_count;
   tlp_len_t              mem_len;

   // Beat count, AXI len is count minus one
   assign beats = LEN_CALC_W'(req.len) + LEN_CALC_W'(1);

   // Doublewords spanned by the burst
   always_comb begin
      case (req.size)
         3'd0: begin
            // Byte beats, round up to whole DWs
            dw_count = (beats + LEN_CALC_W'(3)) >> 2;
         end
         3'd1: begin
            // Halfword beats, two per DW
            dw_count = (beats + LEN_CALC_W'(1)) >> 1;
         end
         default: begin
            // 4 bytes or more per beat, 2^(size-2) DWs each
            dw_count = beats << (req.size - 3'd2);
         end
      endcase
   end

   // Length field wraps at 1024 DW
   assign mem_len = dw_count[TLP_LEN_W-1:0];

   always_comb begin
      length   = '0;
      first_be = '0;
      last_be  = '0;
      case (req.kind)
         KIND_MEM32, KIND_MEM64: begin
            length   = mem_len;
            first_be = 4'b1111;
            // Single DW request has no last DW
            if (mem_len == tlp_len_t'(1)) begin
               last_be = 4'b0000;
            end else begin
               last_be = 4'b1111;
            end
         end
         KIND_IO32: begin
            // I/O reads are always one DW
            length  = tlp_len_t'(1);
            last_be = 4'b0000;
            // Low address bits trim the leading bytes
            case (req.addr[1:0])
               2'b00:   first_be = 4'b1111;
               2'b01:   first_be = 4'b1110;
               2'b10:   first_be = 4'b1100;
               default: first_be = 4'b1000;
            endcase
         end
         default: begin
            length   = '0;
            first_be = '0;
            last_be  = '0;
         end
      endcase
   end

endmodule

// File: design/rd_tag_recorder.sv
// Read tag generation and request recorder write
// Maps the AXI ID to a unique read tag and, on an arbiter grant,
// records the presented header's ID at its tag
module rd_tag_recorder (
   ar_req_if.tag                     req,
   output rd_atop_pkg::tlp_tag_t     tag,
   input  rd_atop_pkg::tlp_tag_t     hdr_tag,
   input  rd_atop_pkg::ar_id_t       hdr_id,
   input  logic                      rd_grant,
   output logic                      rec_wr_en,
   output rd_atop_pkg::tlp_tag_t     rec_wr_addr,
   output rd_atop_pkg::rec_data_t    rec_wr_data
);
   import rd_atop_pkg::*;

   // Read mark on top, scrambled low ID bits, then the ID itself
   // Low nibble keeps the tag unique per ID
   assign tag = {TAG_READ_MARK, req.id[2:0] ^ TAG_SCRAMBLE, req.id};

   // Recorder write follows the grant in the same cycle
   // Uses the registered header values, not the current input
   always_comb begin
      if (rd_grant) begin
         rec_wr_en   = 1'b1;
         rec_wr_addr = hdr_tag;
         rec_wr_data = {hdr_id, 1'b1};
      end else begin
         rec_wr_en   = 1'b0;
         rec_wr_addr = '0;
         rec_wr_data = '0;
      end
   end

endmodule

// File: design/rd_hdr_build.sv
// TLP read request header assembly
// Builds the 4 DW memory or I/O read header from the decoded request,
// then registers header, valid, tag and ID for one cycle of latency
module rd_hdr_build (
   input  logic                          clk,
   input  logic                          rst,
   ar_req_if.header                      req,
   input  rd_atop_pkg::requester_id_t    requester_id,
   input  rd_atop_pkg::tlp_len_t         length,
   input  rd_atop_pkg::dw_be_t           first_be,
   input  rd_atop_pkg::dw_be_t           last_be,
   input  rd_atop_pkg::tlp_tag_t         tag,
   output rd_atop_pkg::tlp_hdr_t         hdr,
   output logic                          hdr_valid,
   output rd_atop_pkg::tlp_tag_t         hdr_tag,
   output rd_atop_pkg::ar_id_t           hdr_id
);
   import rd_atop_pkg::*;

   logic [2:0]      fmt;
   logic [4:0]      typ;
   logic [DW_W-1:0] dw0;
   logic [DW_W-1:0] dw1;
   logic [DW_W-1:0] dw2;
   logic [DW_W-1:0] dw3;
   tlp_hdr_t        hdr_next;
   logic            valid_next;

   // Format, type and address placement per kind
   always_comb begin
      fmt        = FMT_3DW_NO_DATA;
      typ        = TYPE_MEM_RD;
      dw2        = {req.addr[31:2], 2'b00};
      dw3        = '0;
      valid_next = 1'b1;
      case (req.kind)
         KIND_MEM32: begin
            fmt = FMT_3DW_NO_DATA;
            typ = TYPE_MEM_RD;
         end
         KIND_IO32: begin
            fmt = FMT_3DW_NO_DATA;
            typ = TYPE_IO_RD;
         end
         KIND_MEM64: begin
            fmt = FMT_4DW_NO_DATA;
            typ = TYPE_MEM_RD;
            // Upper address first, lower DW carries PH = 00
            dw2 = req.addr[63:32];
            dw3 = {req.addr[31:2], 2'b00};
         end
         default: begin
            valid_next = 1'b0;
         end
      endcase
   end

   // DW0, T9 T8 LN TD EP AT all zero
   assign dw0 = {fmt, typ, 1'b0, HDR_TC, 1'b0, HDR_ATTR2, 1'b0, HDR_TH,
                 1'b0, 1'b0, HDR_ATTR, 2'b00, length};

   // DW1, requester ID, tag, then byte enables
   assign dw1 = {requester_id, tag, last_be, first_be};

   // No request means an all zero header
   assign hdr_next = valid_next ? {dw0, dw1, dw2, dw3} : '0;

   // Output register
   always_ff @(posedge clk) begin
      if (rst) begin
         hdr       <= '0;
         hdr_valid <= 1'b0;
      end else begin
         hdr       <= hdr_next;
         hdr_valid <= valid_next;
      end
   end

   // Tag and ID of the presented header for the recorder write
   // Low tag bits are the AXI ID unchanged
   always_ff @(posedge clk) begin
      hdr_tag <= tag;
      hdr_id  <= tag[ID_W-1:0];
   end

endmodule

// File: design/rd_atop.sv
// AXI to PCIe read request mapper, top level
// Turns AR FIFO entries into registered TLP read headers and writes
// the request recorder when the arbiter grants a header
module rd_atop (
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          rd_atop_en,
   input  rd_atop_pkg::ar_word_t         ar_fifo_data,
   input  rd_atop_pkg::requester_id_t    requester_id,
   input  logic                          rd_grant,
   output rd_atop_pkg::tlp_hdr_t         hdr,
   output logic                          hdr_valid,
   output logic                          rec_wr_en,
   output rd_atop_pkg::tlp_tag_t         rec_wr_addr,
   output rd_atop_pkg::rec_data_t        rec_wr_data
);
   import rd_atop_pkg::*;

   tlp_len_t length;
   dw_be_t   first_be;
   dw_be_t   last_be;
   tlp_tag_t tag;
   tlp_tag_t hdr_tag;
   ar_id_t   hdr_id;

   // Decoded AR request shared by the blocks below
   ar_req_if req_if ();

   rd_req_decode u_decode (
      .ar_fifo_data (ar_fifo_data),
      .rd_atop_en   (rd_atop_en),
      .req          (req_if.decoder)
   );

   rd_len_be_calc u_len_be (
      .req      (req_if.length),
      .length   (length),
      .first_be (first_be),
      .last_be  (last_be)
   );

   // Tag comes out combinationally, recorder uses the registered copy
   rd_tag_recorder u_tag_rec (
      .req         (req_if.tag),
      .tag         (tag),
      .hdr_tag     (hdr_tag),
      .hdr_id      (hdr_id),
      .rd_grant    (rd_grant),
      .rec_wr_en   (rec_wr_en),
      .rec_wr_addr (rec_wr_addr),
      .rec_wr_data (rec_wr_data)
   );

   rd_hdr_build u_hdr (
      .clk          (clk),
      .rst          (rst),
      .req          (req_if.header),
      .requester_id (requester_id),
      .length       (length),
      .first_be     (first_be),
      .last_be      (last_be),
      .tag          (tag),
      .hdr          (hdr),
      .hdr_valid    (hdr_valid),
      .hdr_tag      (hdr_tag),
      .hdr_id       (hdr_id)
   );

endmodule

// File: tb/rd_atop_checker.sv
// Output protocol checker for the read request mapper
// Bound to the top level, watches reset behavior, the recorder
// write against the arbiter grant and the idle header value
module rd_atop_checker (
   input logic                       clk,
   input logic                       rst,
   input rd_atop_pkg::tlp_hdr_t      hdr,
   input logic                       hdr_valid,
   input logic                       rd_grant,
   input logic                       rec_wr_en
);
   import rd_atop_pkg::*;

   // Header register clears on reset
   assert property (@(posedge clk) rst |=> !hdr_valid)
      else $error("hdr_valid high in the cycle after reset");

   // Recorder write is a direct copy of the grant
   assert property (@(posedge clk) rec_wr_en == rd_grant)
      else $error("rec_wr_en does not follow rd_grant");

   // No request means an all zero header
   assert property (@(posedge clk) disable iff (rst) !hdr_valid |-> hdr == '0)
      else $error("hdr not zero while hdr_valid is low");

endmodule

bind rd_atop rd_atop_checker u_checker (
   .clk       (clk),
   .rst       (rst),
   .hdr       (hdr),
   .hdr_valid (hdr_valid),
   .rd_grant  (rd_grant),
   .rec_wr_en (rec_wr_en)
);

// File: tb/tb_rd_atop.sv
// Testbench for the AXI read to PCIe read request mapper
// Applies a hand-built table of AR requests back to back, checks the
// registered header one cycle later and the recorder write on grant
module tb_rd_atop;
   import rd_atop_pkg::*;

   localparam int PERIOD = 40;
   localparam int NUM_CASES = 16;
   // Three periods per entry plus reset
   localparam int TIMEOUT = (NUM_CASES * 3 + 2) * PERIOD;

   typedef struct {
      logic          en;
      ar_user_t      user;
      ax_size_t      size;
      ax_len_t       len;
      axi_addr_t     addr;
      ar_id_t        id;
      requester_id_t rid;
      logic          grant;
      tlp_hdr_t      exp_hdr;
      logic          exp_valid;
      tlp_tag_t      exp_rec_addr;
      rec_data_t     exp_rec_data;
   } case_t;

   logic          clk;
   logic          rst;
   logic          rd_atop_en;
   ar_word_t      ar_fifo_data;
   requester_id_t requester_id;
   logic          rd_grant;
   tlp_hdr_t      hdr;
   logic          hdr_valid;
   logic          rec_wr_en;
   tlp_tag_t      rec_wr_addr;
   rec_data_t     rec_wr_data;

   case_t cases [NUM_CASES];
   int    fill_idx = 0;

   rd_atop dut (
      .clk          (clk),
      .rst          (rst),
      .rd_atop_en   (rd_atop_en),
      .ar_fifo_data (ar_fifo_data),
      .requester_id (requester_id),
      .rd_grant     (rd_grant),
      .hdr          (hdr),
      .hdr_valid    (hdr_valid),
      .rec_wr_en    (rec_wr_en),
      .rec_wr_addr  (rec_wr_addr),
      .rec_wr_data  (rec_wr_data)
   );

   initial clk = 1'b0;
   always #(PERIOD / 2) clk = ~clk;

   task automatic add_case(input logic en, input ar_user_t user, input ax_size_t size,
                           input ax_len_t len, input axi_addr_t addr, input ar_id_t id,
                           input requester_id_t rid, input logic grant,
                           input tlp_hdr_t exp_hdr, input logic exp_valid,
                           input tlp_tag_t exp_rec_addr, input rec_data_t exp_rec_data);
      cases[fill_idx] = '{en, user, size, len, addr, id, rid, grant,
                          exp_hdr, exp_valid, exp_rec_addr, exp_rec_data};
      fill_idx++;
   endtask

   // FIFO word from bit 0 up: user, size, len, addr, id
   task automatic drive_inputs(input case_t c);
      rd_atop_en   = c.en;
      ar_fifo_data = {c.id, c.addr, c.len, c.size, c.user};
      requester_id = c.rid;
   endtask

   task automatic check_value(input string name, input logic [127:0] actual,
                              input logic [127:0] expected);
      if (actual !== expected) begin
         $display("** Error: time %0t: %s = 0x%0h, expected 0x%0h",
                  $time, name, actual, expected);
         $display("Simulation failed");
         $fatal(1, "Value mismatch on %s", name);
      end
   endtask

   // Hand-worked entries, header as DW0 DW1 DW2 DW3
   task automatic fill_table();
      // Idle: disabled, user 00, user 11, 64-bit I/O
      add_case(0, 3'b001, 3'd2, 8'd0, 64'h1000, 4'd1, 16'h0108, 0, '0, 0, 8'h00, 5'h00);
      add_case(1, 3'b000, 3'd2, 8'd0, 64'h1000, 4'd1, 16'h0108, 0, '0, 0, 8'h00, 5'h00);
      add_case(1, 3'b011, 3'd2, 8'd0, 64'h1000, 4'd1, 16'h0108, 0, '0, 0, 8'h00, 5'h00);
      add_case(1, 3'b110, 3'd2, 8'd0, 64'h1000, 4'd1, 16'h0108, 0, '0, 0, 8'h00, 5'h00);
      // 32-bit memory reads, lengths from size and beat count
      add_case(1, 3'b001, 3'd0, 8'd2, 64'h1234_5677, 4'd3, 16'h0108, 1,
               {32'h00052001, 32'h0108930F, 32'h12345674, 32'h0}, 1, 8'h93, 5'h07);
      add_case(1, 3'b001, 3'd0, 8'd4, 64'h8000_0003, 4'd5, 16'h0108, 0,
               {32'h00052002, 32'h0108F5FF, 32'h80000000, 32'h0}, 1, 8'h00, 5'h00);
      add_case(1, 3'b001, 3'd1, 8'd2, 64'h0000_0102, 4'd7, 16'h0108, 1,
               {32'h00052002, 32'h0108D7FF, 32'h00000100, 32'h0}, 1, 8'hD7, 5'h0F);
      add_case(1, 3'b001, 3'd3, 8'd3, 64'hABCD_EF01, 4'd10, 16'h1234, 0,
               {32'h00052008, 32'h12348AFF, 32'hABCDEF00, 32'h0}, 1, 8'h00, 5'h00);
      add_case(1, 3'b001, 3'd2, 8'd0, 64'hFFFF_FFFF_0000_0010, 4'd15, 16'h0108, 1,
               {32'h00052001, 32'h0108DF0F, 32'h00000010, 32'h0}, 1, 8'hDF, 5'h1F);
      // I/O reads, first_be from the low address bits
      add_case(1, 3'b010, 3'd2, 8'd3, 64'h2000, 4'd0, 16'h0108, 1,
               {32'h02052001, 32'h0108A00F, 32'h00002000, 32'h0}, 1, 8'hA0, 5'h01);
      add_case(1, 3'b010, 3'd2, 8'd3, 64'h2001, 4'd5, 16'h0108, 1,
               {32'h02052001, 32'h0108F50E, 32'h00002000, 32'h0}, 1, 8'hF5, 5'h0B);
      add_case(1, 3'b010, 3'd2, 8'd3, 64'h2002, 4'd10, 16'h0108, 1,
               {32'h02052001, 32'h01088A0C, 32'h00002000, 32'h0}, 1, 8'h8A, 5'h15);
      add_case(1, 3'b010, 3'd2, 8'd3, 64'h2003, 4'd15, 16'h0108, 1,
               {32'h02052001, 32'h0108DF08, 32'h00002000, 32'h0}, 1, 8'hDF, 5'h1F);
      // 64-bit memory reads, upper address in DW2
      add_case(1, 3'b101, 3'd2, 8'd1, 64'h1234_5678_9ABC_DEF3, 4'd1, 16'h0108, 1,
               {32'h20052002, 32'h0108B1FF, 32'h12345678, 32'h9ABCDEF0}, 1, 8'hB1, 5'h03);
      add_case(1, 3'b101, 3'd4, 8'd0, 64'h0000_0001_0000_0004, 4'd0, 16'h1234, 0,
               {32'h20052004, 32'h1234A0FF, 32'h00000001, 32'h00000004}, 1, 8'h00, 5'h00);
      // Back to idle
      add_case(0, 3'b101, 3'd2, 8'd0, 64'h0, 4'd0, 16'h0108, 0, '0, 0, 8'h00, 5'h00);
   endtask

   initial begin
      rst          = 1'b1;
      rd_atop_en   = 1'b0;
      ar_fifo_data = '0;
      requester_id = '0;
      rd_grant     = 1'b0;
      fill_table();

      repeat (2) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      // Register still holds its reset value
      check_value("hdr_valid after reset", 128'(hdr_valid), 128'(1'b0));
      check_value("hdr after reset", hdr, '0);
      drive_inputs(cases[0]);

      // Each pass checks the previous entry while the next one goes in
      for (int i = 1; i <= NUM_CASES; i++) begin
         @(negedge clk);
         check_value($sformatf("hdr (case %0d)", i - 1), hdr, cases[i-1].exp_hdr);
         check_value($sformatf("hdr_valid (case %0d)", i - 1), 128'(hdr_valid),
                     128'(cases[i-1].exp_valid));
         rd_grant = cases[i-1].grant;
         if (i < NUM_CASES) begin
            drive_inputs(cases[i]);
         end else begin
            rd_atop_en   = 1'b0;
            ar_fifo_data = '0;
         end
         #1;
         // Recorder write is combinational from the grant
         check_value($sformatf("rec_wr_en (case %0d)", i - 1), 128'(rec_wr_en),
                     128'(cases[i-1].grant));
         check_value($sformatf("rec_wr_addr (case %0d)", i - 1), 128'(rec_wr_addr),
                     128'(cases[i-1].exp_rec_addr));
         check_value($sformatf("rec_wr_data (case %0d)", i - 1), 128'(rec_wr_data),
                     128'(cases[i-1].exp_rec_data));
      end

      @(negedge clk);
      rd_grant = 1'b0;
      @(negedge clk);
      $display("Simulation passed");
      $finish;
   end

   // Watchdog
   initial begin
      #(TIMEOUT);
      $display("Timeout: the test table did not complete in time");
      $display("Simulation failed");
      $fatal(1, "Watchdog expired");
   end

endmodule

// File: sim.f
design/rd_atop_pkg.sv
design/ar_req_if.sv
design/rd_req_decode.sv
design/rd_len_be_calc.sv
design/rd_tag_recorder.sv
design/rd_hdr_build.sv
design/rd_atop.sv
tb/rd_atop_checker.sv
tb/tb_rd_atop.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the read mapper testbench with Verilator
set -e

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f sim.f --top-module tb_rd_atop -o sim_rd_atop

# tee keeps the log even when the simulation exits with an error
./obj_dir/sim_rd_atop 2>&1 | tee sim.log

if grep -q "Simulation failed" sim.log; then
   echo "Result: FAIL"
   exit 1
fi
if ! grep -q "Simulation passed" sim.log; then
   echo "Result: FAIL, no pass line in sim.log"
   exit 1
fi
echo "Result: PASS"
